// File: src.f
+incdir+design
design/timerPkg.sv
design/timerIfs.sv
design/timerRegs.sv
design/timerCounter.sv
design/outputCompare.sv
design/irqFlags.sv
design/timerTop.sv
test/timer_assert.sv
test/timerTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module timerTb -f src.f
./obj_dir/VtimerTb

// File: test/timerTb.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module timerTb;
	localparam logic [3:0] OP_IOW = 0, OP_IOWR = 1, OP_RAMW = 2, OP_IOR = 3, OP_RAMR = 4;
	localparam logic [3:0] OP_TICK = 5, OP_ACK = 6;
	localparam logic [8:0] MDL = 9'h100;  // Expected value comes from the model

	typedef struct packed {
		logic [3:0] op;
		logic [11:0] addr;
		logic [7:0] data;
		logic [15:0] n;
		logic [8:0] exp;
	} row_t;

	logic ireset, cp2, cp2en, tmr_cp2en, clk_en, iore, iowe, ramre, ramwe, irqack;
	logic [5:0] IO_Addr, irqack_addr;
	logic [11:0] ram_Addr;
	logic [7:0] dbus_in, dbus_out;
	logic out_en, OCnA, OCnB, OCnA_EN, OCnB_EN, TCnOvfIRQ, TCnCmpAIRQ, TCnCmpBIRQ;
	logic [2:0] csn;
	row_t rows[$];
	int cycles = 0;
	int limit = 0;
	// Reference model state
	logic [7:0] mTccrA, mTcnt, mBufA, mBufB, mActA, mActB;
	logic [3:0] mTccrB;
	logic [2:0] mTifr, mTimsk;
	logic mOcA, mOcB;

	timerTop DUT (.*);

	initial begin
		cp2 = 1'b0;
		forever #2 cp2 = ~cp2;
	end

	always @(posedge cp2) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("test failed");
			$fatal(1, "timeout, run did not finish");
		end
	end

	task automatic check(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (exp !== got) begin
			$display("Error %s expected %h got %h", name, exp, got);
			$display("test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic addRow(input logic [3:0] op, input logic [11:0] addr, input logic [7:0] data,
		input int n, input logic [8:0] exp);
		rows.push_back({op, addr, data, n[15:0], exp});
	endtask

	function automatic logic ocStep(input logic cur, input logic [1:0] com, input logic match,
		input logic bot, input logic fast, input logic tglOk);
		if (com == 2'b00)
			return 1'b0;
		if (!fast)
			return match ? ((com == 2'b01) ? ~cur : com[0]) : cur;
		if (com == 2'b01)
			return tglOk ? (match ? ~cur : cur) : 1'b0;
		if (match)
			return com[0];  // 10 clears, 11 sets
		return bot ? ~com[0] : cur;
	endfunction

	// Toggle drives the pin in non-PWM modes, and on channel A also in FAST_OCR
	function automatic logic pinEnable(input logic [1:0] com, input logic [2:0] mode,
		input logic chanA);
		if (com[1])
			return 1'b1;
		if (!com[0])
			return 1'b0;
		return (mode == 3'd0) || (mode == 3'd2) || (chanA && mode == 3'd7);
	endfunction

	function automatic logic mapped(input logic isRam, input logic [11:0] a);
		if (isRam)
			return a == `TIMSK_ADDR;
		return a[5:0] inside {`TCCRA_ADDR, `TCCRB_ADDR, `TCNT_ADDR, `OCRA_ADDR, `OCRB_ADDR,
			`TIFR_ADDR};
	endfunction

	function automatic logic [7:0] modelRead(input logic isRam, input logic [11:0] a);
		if (isRam)
			return {5'd0, mTimsk};
		case (a[5:0])
			`TCCRA_ADDR: return mTccrA;
			`TCCRB_ADDR: return {4'd0, mTccrB};
			`TCNT_ADDR: return mTcnt;
			`OCRA_ADDR: return mBufA;
			`OCRB_ADDR: return mBufB;
			`TIFR_ADDR: return {5'd0, mTifr};
			default: return 8'h00;
		endcase
	endfunction

	task automatic modelWrite(input logic [5:0] a, input logic [7:0] d);
		logic nonPwm;
		case (a)
			`TCCRA_ADDR: mTccrA = {d[7:4], 2'b00, d[1:0]};
			`TCCRB_ADDR: mTccrB = d[3:0];
			`TCNT_ADDR: mTcnt = d;
			`OCRA_ADDR: mBufA = d;
			`OCRB_ADDR: mBufB = d;
			`TIFR_ADDR: mTifr = mTifr & ~d[2:0];
			default: ;
		endcase
		nonPwm = ({mTccrB[3], mTccrA[1:0]} inside {3'd0, 3'd2});
		if (nonPwm && a == `OCRA_ADDR)
			mActA = d;
		if (nonPwm && a == `OCRB_ADDR)
			mActB = d;
		if (nonPwm && a == `TCCRB_ADDR && d[7])  // Force compare A
			mOcA = ocStep(mOcA, mTccrA[7:6], 1'b1, 1'b0, 1'b0, 1'b0);
		if (nonPwm && a == `TCCRB_ADDR && d[6])
			mOcB = ocStep(mOcB, mTccrA[5:4], 1'b1, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic modelTick();
		logic [2:0] mode;
		logic [7:0] top;
		logic fast, ctcTop, mA, mB, bot, ovf;
		mode = {mTccrB[3], mTccrA[1:0]};
		fast = (mode == 3'd3) || (mode == 3'd7);
		if (!(fast || mode == 3'd0 || mode == 3'd2))
			return;  // Unsupported modes hold
		ctcTop = (mode == 3'd2) || (mode == 3'd7);
		top = ctcTop ? mActA : 8'hFF;
		mA = (mTcnt == mActA);
		mB = (mTcnt == mActB);
		bot = (mTcnt == 8'h00);
		ovf = (mode == 3'd7) ? (mTcnt == top) : (mTcnt == 8'hFF);
		mTifr = mTifr | {mB, mA, ovf};
		mOcA = ocStep(mOcA, mTccrA[7:6], mA, bot, fast, mode == 3'd7);
		mOcB = ocStep(mOcB, mTccrA[5:4], mB, bot, fast, 1'b0);
		if (fast && mTcnt == top) begin
			mActA = mBufA;
			mActB = mBufB;
		end
		mTcnt = (ctcTop && mTcnt == top) ? 8'h00 : mTcnt + 8'h01;
	endtask

	task automatic checkOuts();
		logic [2:0] mode;
		mode = {mTccrB[3], mTccrA[1:0]};
		check("OCnA", {7'd0, mOcA}, {7'd0, OCnA});
		check("OCnB", {7'd0, mOcB}, {7'd0, OCnB});
		check("OCnA_EN", {7'd0, pinEnable(mTccrA[7:6], mode, 1'b1)}, {7'd0, OCnA_EN});
		check("OCnB_EN", {7'd0, pinEnable(mTccrA[5:4], mode, 1'b0)}, {7'd0, OCnB_EN});
		check("csn", {5'd0, mTccrB[2:0]}, {5'd0, csn});
		check("IRQ", {5'd0, mTifr & mTimsk}, {5'd0, TCnCmpBIRQ, TCnCmpAIRQ, TCnOvfIRQ});
	endtask

	task automatic idle();
		{iore, iowe, ramre, ramwe, irqack, tmr_cp2en, clk_en} = '0;
		@(negedge cp2);
	endtask

	task automatic applyRow(input row_t r);
		logic [7:0] d;
		logic isRam;
		d = (r.op == OP_IOWR) ? 8'($urandom) : r.data;
		isRam = (r.op == OP_RAMR);
		case (r.op)
			OP_IOW, OP_IOWR: begin
				IO_Addr = r.addr[5:0];
				dbus_in = d;
				iowe = 1'b1;
				modelWrite(r.addr[5:0], d);
				@(negedge cp2);
			end
			OP_RAMW: begin
				ram_Addr = r.addr;
				dbus_in = d;
				ramwe = 1'b1;
				if (r.addr == `TIMSK_ADDR)
					mTimsk = d[2:0];
				@(negedge cp2);
			end
			OP_IOR, OP_RAMR: begin
				IO_Addr = r.addr[5:0];
				ram_Addr = r.addr;
				iore = !isRam;
				ramre = isRam;
				#1;
				check("dbus_out", r.exp[8] ? modelRead(isRam, r.addr) : r.exp[7:0], dbus_out);
				check("out_en", {7'd0, mapped(isRam, r.addr)}, {7'd0, out_en});
			end
			OP_TICK: begin
				for (int i = 0; i < r.n; i++) begin
					tmr_cp2en = 1'b1;
					clk_en = 1'b1;
					modelTick();
					@(negedge cp2);
					checkOuts();
				end
				checkOuts();
			end
			default: begin  // Interrupt acknowledge
				irqack = 1'b1;
				irqack_addr = r.addr[5:0];
				mTifr[0] = mTifr[0] & (r.addr[5:0] != `VEC_OVF);
				mTifr[1] = mTifr[1] & (r.addr[5:0] != `VEC_CMPA);
				mTifr[2] = mTifr[2] & (r.addr[5:0] != `VEC_CMPB);
				@(negedge cp2);
			end
		endcase
		idle();
	endtask

	initial begin
		int seed;
		seed = 96;
		void'($urandom(seed));
		{ireset, cp2en, tmr_cp2en, clk_en, iore, iowe, ramre, ramwe, irqack} = '0;
		{IO_Addr, irqack_addr, ram_Addr, dbus_in} = '0;
		{mTccrA, mTcnt, mBufA, mBufB, mActA, mActB, mTccrB, mTifr, mTimsk, mOcA, mOcB} = '0;
		// Register access
		addRow(OP_IOW, `TCCRA_ADDR, 8'hA5, 0, 0);
		addRow(OP_IOR, `TCCRA_ADDR, 0, 0, 9'h0A1);
		addRow(OP_TICK, 0, 0, 0, 0);  // Pin enables from COM bits
		addRow(OP_IOW, `TCCRA_ADDR, 8'h00, 0, 0);
		addRow(OP_IOW, `TCCRB_ADDR, 8'hC5, 0, 0);
		addRow(OP_IOR, `TCCRB_ADDR, 0, 0, 9'h005);
		addRow(OP_TICK, 0, 0, 0, 0);  // Clock select out
		addRow(OP_IOW, `TCCRB_ADDR, 8'h00, 0, 0);
		addRow(OP_IOW, `OCRA_ADDR, 8'h3C, 0, 0);
		addRow(OP_IOR, `OCRA_ADDR, 0, 0, 9'h03C);
		addRow(OP_IOW, `OCRB_ADDR, 8'h99, 0, 0);
		addRow(OP_IOR, `OCRB_ADDR, 0, 0, 9'h099);
		addRow(OP_RAMW, `TIMSK_ADDR, 8'h07, 0, 0);
		addRow(OP_RAMR, `TIMSK_ADDR, 0, 0, 9'h007);
		addRow(OP_IOR, 12'h02E, 0, 0, 9'h000);
		addRow(OP_RAMR, 12'h06F, 0, 0, 9'h000);
		addRow(OP_IOR, 12'h03F, 0, 0, 9'h000);
		addRow(OP_RAMW, `TIMSK_ADDR, 8'h00, 0, 0);
		// Normal mode from a random start
		addRow(OP_IOWR, `TCNT_ADDR, 0, 0, 0);
		addRow(OP_TICK, 0, 0, 300, 0);
		addRow(OP_IOR, `TCNT_ADDR, 0, 0, MDL);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, MDL);
		addRow(OP_RAMW, `TIMSK_ADDR, 8'h01, 0, 0);
		addRow(OP_TICK, 0, 0, 0, 0);
		addRow(OP_IOW, `TIFR_ADDR, 8'h01, 0, 0);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, MDL);
		addRow(OP_TICK, 0, 0, 0, 0);
		// CTC, TOP at compare A
		addRow(OP_IOW, `OCRA_ADDR, 8'h05, 0, 0);
		addRow(OP_IOW, `TIFR_ADDR, 8'h07, 0, 0);
		addRow(OP_IOW, `TCNT_ADDR, 8'h00, 0, 0);
		addRow(OP_IOW, `TCCRA_ADDR, 8'h42, 0, 0);
		addRow(OP_TICK, 0, 0, 3, 0);
		addRow(OP_IOR, `TCNT_ADDR, 0, 0, 9'h003);
		addRow(OP_TICK, 0, 0, 3, 0);
		addRow(OP_IOR, `TCNT_ADDR, 0, 0, 9'h000);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, 9'h002);
		addRow(OP_TICK, 0, 0, 12, 0);
		addRow(OP_IOW, `TCCRB_ADDR, 8'h80, 0, 0);
		addRow(OP_TICK, 0, 0, 0, 0);
		// Fast PWM, buffered compare B
		addRow(OP_IOW, `OCRB_ADDR, 8'h40, 0, 0);
		addRow(OP_IOW, `TCCRA_ADDR, 8'h23, 0, 0);
		addRow(OP_IOW, `TCNT_ADDR, 8'hF0, 0, 0);
		addRow(OP_TICK, 0, 0, 20, 0);
		addRow(OP_IOW, `OCRB_ADDR, 8'h80, 0, 0);
		addRow(OP_IOR, `OCRB_ADDR, 0, 0, 9'h080);
		addRow(OP_TICK, 0, 0, 400, 0);  // Runs past 0x80 after the reload at TOP
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, 9'h007);
		// Acknowledge by vector
		addRow(OP_RAMW, `TIMSK_ADDR, 8'h07, 0, 0);
		addRow(OP_ACK, `VEC_CMPB, 0, 0, 0);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, 9'h003);
		addRow(OP_ACK, 12'h011, 0, 0, 0);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, 9'h003);
		addRow(OP_ACK, `VEC_OVF, 0, 0, 0);
		addRow(OP_IOR, `TIFR_ADDR, 0, 0, 9'h002);
		addRow(OP_TICK, 0, 0, 0, 0);
		limit = rows.size() * 300;
		repeat (5) @(posedge cp2);
		@(negedge cp2);
		ireset = 1'b1;
		cp2en = 1'b1;
		@(negedge cp2);
		checkOuts();
		foreach (rows[i])
			applyRow(rows[i]);
		$display("test passed");
		$finish;
	end
endmodule

// File: test/timer_assert.sv
`timescale 1ns/1ps

module timerAssert (
	input logic cp2,
	input logic ireset,
	input logic iore,
	input logic ramre,
	input logic out_en,
	input logic [2:0] maskBits,
	input logic [7:0] tccrA,
	input logic TCnOvfIRQ,
	input logic TCnCmpAIRQ,
	input logic TCnCmpBIRQ,
	input logic OCnA_EN,
	input logic OCnB_EN
);
	ovfMasked: assert property (@(posedge cp2) disable iff (!ireset) TCnOvfIRQ |-> maskBits[0])
		else $error("overflow IRQ raised with its mask bit clear");
	cmpAMasked: assert property (@(posedge cp2) disable iff (!ireset) TCnCmpAIRQ |-> maskBits[1])
		else $error("compare A IRQ raised with its mask bit clear");
	cmpBMasked: assert property (@(posedge cp2) disable iff (!ireset) TCnCmpBIRQ |-> maskBits[2])
		else $error("compare B IRQ raised with its mask bit clear");
	// Bus is only driven during a read
	noReadNoEn: assert property (@(posedge cp2) disable iff (!ireset) !(iore || ramre) |-> !out_en)
		else $error("out_en high without a read strobe");
	pinsOff: assert property (@(posedge cp2) disable iff (!ireset)
		(tccrA == 8'h00) |-> !(OCnA_EN || OCnB_EN))
		else $error("pin enable high while control A is zero");
endmodule

bind timerTop timerAssert chk (.cp2, .ireset, .iore, .ramre, .out_en, .maskBits,
	.tccrA(regs.tccrA), .TCnOvfIRQ, .TCnCmpAIRQ, .TCnCmpBIRQ, .OCnA_EN, .OCnB_EN);

// File: design/timerTop.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module timerTop (
	input logic ireset,
	input logic cp2,
	input logic cp2en,
	input logic tmr_cp2en,
	input logic clk_en,
	input logic [`TMR_IO_AW-1:0] IO_Addr,
	input logic iore,
	input logic iowe,
	input logic [`TMR_RAM_AW-1:0] ram_Addr,
	input logic ramre,
	input logic ramwe,
	input logic [`TMR_DW-1:0] dbus_in,
	output logic [`TMR_DW-1:0] dbus_out,
	output logic out_en,
	input logic irqack,
	input logic [`TMR_IO_AW-1:0] irqack_addr,
	output logic [2:0] csn,
	output logic OCnA,
	output logic OCnB,
	output logic OCnA_EN,
	output logic OCnB_EN,
	output logic TCnOvfIRQ,
	output logic TCnCmpAIRQ,
	output logic TCnCmpBIRQ
);
	logic [2:0] tifr;
	logic [2:0] maskBits;

	timerCtrlIf ctrlBus();
	cntEventIf evBus();

	timerRegs regs (.ireset, .cp2, .cp2en, .IO_Addr, .iore, .iowe, .ram_Addr, .ramre,
		.ramwe, .dbus_in, .tifr, .dbus_out, .out_en, .csn, .maskBits,
		.ctrl(ctrlBus.regs), .ev(evBus.sink));

	timerCounter cnt (.ireset, .cp2, .cp2en, .tmr_cp2en, .clk_en,
		.ctrl(ctrlBus.cnt), .ev(evBus.src));

	outputCompare #(.pwmToggle(1'b1)) ocA (.ireset, .cp2, .com(ctrlBus.comA),
		.foc(ctrlBus.focA), .ocr(ctrlBus.ocrA), .ctrl(ctrlBus.oc), .ev(evBus.sink),
		.oc(OCnA), .ocEn(OCnA_EN));

	outputCompare #(.pwmToggle(1'b0)) ocB (.ireset, .cp2, .com(ctrlBus.comB),
		.foc(ctrlBus.focB), .ocr(ctrlBus.ocrB), .ctrl(ctrlBus.oc), .ev(evBus.sink),
		.oc(OCnB), .ocEn(OCnB_EN));

	irqFlags flags (.ireset, .cp2, .cp2en, .IO_Addr, .iowe, .dbus_in, .irqack, .irqack_addr,
		.maskBits, .ctrl(ctrlBus.flags), .ev(evBus.sink), .tifr, .TCnOvfIRQ, .TCnCmpAIRQ,
		.TCnCmpBIRQ);

endmodule

// File: design/irqFlags.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module irqFlags (
	input logic ireset,
	input logic cp2,
	input logic cp2en,
	input logic [`TMR_IO_AW-1:0] IO_Addr,
	input logic iowe,
	input logic [`TMR_DW-1:0] dbus_in,
	input logic irqack,
	input logic [`TMR_IO_AW-1:0] irqack_addr,
	input logic [2:0] maskBits,
	timerCtrlIf.flags ctrl,
	cntEventIf.sink ev,
	output logic [2:0] tifr,
	output logic TCnOvfIRQ,
	output logic TCnCmpAIRQ,
	output logic TCnCmpBIRQ
);
	logic [2:0] setEv;
	logic [2:0] clrEv;
	logic [2:0] ack;
	logic modeOk;
	logic ovfHit;
	logic wrTifr;

	assign modeOk = (ctrl.wgm == timerPkg::NORMAL) || (ctrl.wgm == timerPkg::CTC) ||
		timerPkg::isFastPwm(ctrl.wgm);
	assign ovfHit = (ctrl.wgm == timerPkg::FAST_OCR) ? (ev.tcnt == ev.top) :
		(ev.tcnt == `TMR_MAX);
	assign setEv[0] = ev.tick && modeOk && ovfHit;
	assign setEv[1] = ev.tick && modeOk && (ev.tcnt == ctrl.ocrA);
	assign setEv[2] = ev.tick && modeOk && (ev.tcnt == ctrl.ocrB);

	assign ack[0] = irqack && (irqack_addr == `VEC_OVF);
	assign ack[1] = irqack && (irqack_addr == `VEC_CMPA);
	assign ack[2] = irqack && (irqack_addr == `VEC_CMPB);
	assign wrTifr = iowe && (IO_Addr == `TIFR_ADDR);
	assign clrEv = (ack | ({3{wrTifr}} & dbus_in[2:0])) & {3{cp2en}};  // Write one to clear

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tifr <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (tifr[i]) begin
					if (clrEv[i])
						tifr[i] <= 1'b0;
				end else if (setEv[i]) begin
					tifr[i] <= 1'b1;
				end
			end
		end
	end

	assign TCnOvfIRQ = tifr[0] & maskBits[0];
	assign TCnCmpAIRQ = tifr[1] & maskBits[1];
	assign TCnCmpBIRQ = tifr[2] & maskBits[2];

endmodule

// File: design/outputCompare.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module outputCompare #(
	parameter bit pwmToggle = 1'b1  // Channel A allows toggle in FAST_OCR
) (
	input logic ireset,
	input logic cp2,
	input logic [1:0] com,
	input logic foc,
	input logic [`TMR_DW-1:0] ocr,
	timerCtrlIf.oc ctrl,
	cntEventIf.sink ev,
	output logic oc,
	output logic ocEn
);
	logic match;
	logic nonPwm;
	logic fastPwm;
	logic toggleOk;
	logic bottom;

	assign match = (ev.tcnt == ocr);
	assign bottom = (ev.tcnt == '0);
	assign nonPwm = (ctrl.wgm == timerPkg::NORMAL) || (ctrl.wgm == timerPkg::CTC);
	assign fastPwm = timerPkg::isFastPwm(ctrl.wgm);
	assign toggleOk = pwmToggle && (ctrl.wgm == timerPkg::FAST_OCR);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			oc <= 1'b0;
		end else if (!ev.blocked) begin
			if (com == 2'b00 && (nonPwm || fastPwm)) begin
				oc <= 1'b0;  // Disconnected
			end else if (nonPwm && ((ev.tick && match) || foc)) begin
				case (com)
					2'b01: oc <= ~oc;
					2'b10: oc <= 1'b0;
					default: oc <= 1'b1;
				endcase
			end else if (fastPwm && ev.tick) begin
				case (com)
					2'b01: begin
						if (!toggleOk)
							oc <= 1'b0;
						else if (match)
							oc <= ~oc;
					end
					2'b10: begin  // Non-inverting
						if (match)
							oc <= 1'b0;
						else if (bottom)
							oc <= 1'b1;
					end
					default: begin  // Inverting
						if (match)
							oc <= 1'b1;
						else if (bottom)
							oc <= 1'b0;
					end
				endcase
			end
		end
	end

	// Toggle mode drives the pin only where the channel supports it
	assign ocEn = com[1] | (com[0] & (pwmToggle ? (ctrl.wgm[2] | ~ctrl.wgm[0]) :
		(~ctrl.wgm[2] & ~ctrl.wgm[0])));

endmodule

// File: design/timerCounter.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module timerCounter (
	input logic ireset,
	input logic cp2,
	input logic cp2en,
	input logic tmr_cp2en,
	input logic clk_en,
	timerCtrlIf.cnt ctrl,
	cntEventIf.src ev
);
	logic [`TMR_DW-1:0] tcnt;
	logic [`TMR_DW-1:0] top;
	logic tick;
	logic wrFl;  // Counter write pending, blocks compare

	assign tick = tmr_cp2en & clk_en;
	assign top = ((ctrl.wgm == timerPkg::CTC) || (ctrl.wgm == timerPkg::FAST_OCR)) ?
		ctrl.ocrA : `TMR_MAX;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tcnt <= '0;
		end else if (ctrl.tcntWr) begin  // Bus write wins over counting
			tcnt <= ctrl.data;
		end else if (tick) begin
			case (ctrl.wgm)
				timerPkg::NORMAL, timerPkg::FAST_FF:
					tcnt <= tcnt + 1'b1;  // Free-running wrap
				timerPkg::CTC, timerPkg::FAST_OCR:
					tcnt <= (tcnt == top) ? '0 : tcnt + 1'b1;
				default: ;  // Phase correct and reserved hold
			endcase
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wrFl <= 1'b0;
		end else if (cp2en) begin
			if (!wrFl) begin
				if (ctrl.tcntWr && !tick)
					wrFl <= 1'b1;
			end else if (!tick) begin
				wrFl <= 1'b0;  // Released on next idle cycle
			end
		end
	end

	assign ev.tcnt = tcnt;
	assign ev.top = top;
	assign ev.tick = tick;
	assign ev.blocked = wrFl | ctrl.tcntWr;

endmodule

// File: design/timerRegs.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

module timerRegs (
	input logic ireset,
	input logic cp2,
	input logic cp2en,
	input logic [`TMR_IO_AW-1:0] IO_Addr,
	input logic iore,
	input logic iowe,
	input logic [`TMR_RAM_AW-1:0] ram_Addr,
	input logic ramre,
	input logic ramwe,
	input logic [`TMR_DW-1:0] dbus_in,
	input logic [2:0] tifr,
	output logic [`TMR_DW-1:0] dbus_out,
	output logic out_en,
	output logic [2:0] csn,
	output logic [2:0] maskBits,
	timerCtrlIf.regs ctrl,
	cntEventIf.sink ev
);
	logic ioWr;
	logic wrTccrA, wrTccrB, wrOcrA, wrOcrB, wrMask;
	logic [`TMR_DW-1:0] tccrA;
	logic [3:0] tccrB;  // WGM2 and clock select
	logic [1:0] foc;  // Force strobes, self clearing
	logic [`TMR_DW-1:0] ocrABuf, ocrBBuf;
	logic [`TMR_DW-1:0] ocrA, ocrB;
	logic [2:0] timsk;
	logic bufLoad;
	timerPkg::wgmMode_e wgm;

	assign ioWr = iowe & cp2en;
	assign wrTccrA = ioWr && (IO_Addr == `TCCRA_ADDR);
	assign wrTccrB = ioWr && (IO_Addr == `TCCRB_ADDR);
	assign wrOcrA = ioWr && (IO_Addr == `OCRA_ADDR);
	assign wrOcrB = ioWr && (IO_Addr == `OCRB_ADDR);
	assign wrMask = ramwe && cp2en && (ram_Addr == `TIMSK_ADDR);

	assign wgm = timerPkg::wgmMode_e'({tccrB[3], tccrA[1:0]});
	assign bufLoad = ev.tick && (ev.tcnt == ev.top);  // PWM double-buffer update

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tccrA <= `TMR_REG_RST;
			tccrB <= '0;
			foc <= '0;
		end else begin
			if (wrTccrA)
				tccrA <= {dbus_in[7:4], 2'b00, dbus_in[1:0]};  // Bits 3:2 unused
			if (wrTccrB)
				tccrB <= dbus_in[3:0];
			foc <= wrTccrB ? dbus_in[7:6] : 2'b00;
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrABuf <= `TMR_REG_RST;
			ocrBBuf <= `TMR_REG_RST;
			timsk <= '0;
		end else begin
			if (wrOcrA)
				ocrABuf <= dbus_in;
			if (wrOcrB)
				ocrBBuf <= dbus_in;
			if (wrMask)
				timsk <= dbus_in[2:0];
		end
	end

	// Active compare values
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrA <= `TMR_REG_RST;
			ocrB <= `TMR_REG_RST;
		end else begin
			case (wgm)
				timerPkg::NORMAL, timerPkg::CTC: begin  // Unbuffered
					if (wrOcrA)
						ocrA <= dbus_in;
					if (wrOcrB)
						ocrB <= dbus_in;
				end
				timerPkg::FAST_FF, timerPkg::FAST_OCR: begin
					if (bufLoad) begin
						ocrA <= ocrABuf;
						ocrB <= ocrBBuf;
					end
				end
				default: ;  // Unsupported modes hold
			endcase
		end
	end

	assign ctrl.wgm = wgm;
	assign ctrl.comA = tccrA[7:6];
	assign ctrl.comB = tccrA[5:4];
	assign ctrl.focA = foc[1];
	assign ctrl.focB = foc[0];
	assign ctrl.ocrA = ocrA;
	assign ctrl.ocrB = ocrB;
	assign ctrl.tcntWr = ioWr && (IO_Addr == `TCNT_ADDR);
	assign ctrl.data = dbus_in;
	assign csn = tccrB[2:0];  // To external prescaler
	assign maskBits = timsk;

	always_comb begin
		dbus_out = '0;
		out_en = 1'b0;
		if (iore) begin
			out_en = 1'b1;
			case (IO_Addr)
				`TCCRA_ADDR: dbus_out = tccrA;
				`TCCRB_ADDR: dbus_out = {4'b0000, tccrB};  // FOC bits read as zero
				`TCNT_ADDR:  dbus_out = ev.tcnt;
				`OCRA_ADDR:  dbus_out = ocrABuf;
				`OCRB_ADDR:  dbus_out = ocrBBuf;
				`TIFR_ADDR:  dbus_out = {{(`TMR_DW-3){1'b0}}, tifr};
				default:     out_en = 1'b0;
			endcase
		end else if (ramre && (ram_Addr == `TIMSK_ADDR)) begin
			dbus_out = {{(`TMR_DW-3){1'b0}}, timsk};
			out_en = 1'b1;
		end
	end

endmodule

// File: design/timerIfs.sv
`timescale 1ns/1ps
`include "timer_defines.svh"

// Control word from the register block
interface timerCtrlIf;
	timerPkg::wgmMode_e wgm;
	logic [1:0] comA;
	logic [1:0] comB;
	logic focA;  // One-cycle force strobe
	logic focB;
	logic [`TMR_DW-1:0] ocrA;  // Active compare values
	logic [`TMR_DW-1:0] ocrB;
	logic tcntWr;  // Counter write strobe
	logic [`TMR_DW-1:0] data;  // Byte loaded on tcntWr

	modport regs(output wgm, comA, comB, focA, focB, ocrA, ocrB, tcntWr, data);
	modport cnt(input wgm, ocrA, tcntWr, data);
	modport oc(input wgm);
	modport flags(input wgm, ocrA, ocrB);
endinterface

// Counter state seen by the other units
interface cntEventIf;
	logic [`TMR_DW-1:0] tcnt;
	logic [`TMR_DW-1:0] top;
	logic tick;  // Prescaled count enable
	logic blocked;  // Compare output held off

	modport src(output tcnt, top, tick, blocked);
	modport sink(input tcnt, top, tick, blocked);
endinterface

// File: design/timerPkg.sv
package timerPkg;

	// Waveform generation mode, {WGM2, WGM1, WGM0}
	typedef enum logic [2:0] {
		NORMAL   = 3'd0,
		PC_FF    = 3'd1,  // Phase correct, not implemented
		CTC      = 3'd2,
		FAST_FF  = 3'd3,
		PC_OCR   = 3'd5,  // Phase correct, not implemented
		FAST_OCR = 3'd7
	} wgmMode_e;

	// True for both Fast PWM variants
	function automatic logic isFastPwm(input wgmMode_e mode);
		return (mode == FAST_FF) || (mode == FAST_OCR);
	endfunction

endpackage

// File: design/timer_defines.svh
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// Bus and address widths
`define TMR_DW      8
`define TMR_IO_AW   6
`define TMR_RAM_AW  12

// I/O space registers
`define TCCRA_ADDR  6'h24
`define TCCRB_ADDR  6'h25
`define TCNT_ADDR   6'h26
`define OCRA_ADDR   6'h27
`define OCRB_ADDR   6'h28
`define TIFR_ADDR   6'h15

// Mask register sits in data RAM space
`define TIMSK_ADDR  12'h06E

// Interrupt acknowledge vectors
`define VEC_CMPA    6'h0E
`define VEC_CMPB    6'h0F
`define VEC_OVF     6'h10

// Counter limit and register reset value
`define TMR_MAX     8'hFF
`define TMR_REG_RST 8'h00

`endif
